// File: compile.f
+incdir+.
bmd_pkg.sv
bmd_cq_rx.sv
bmd_mem_access.sv
bmd_cc_tx.sv
bmd_rq_tx.sv
bmd_intr_ctrl.sv
bmd_ep_top.sv
tb_bmd_ep.sv

// File: Makefile
TOP = tb_bmd_ep

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f compile.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: tb_bmd_ep.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module tb_bmd_ep;
   import bmd_pkg::*;

   localparam logic [31:0] SEED     = 32'h1751;
   localparam int          N_REQ    = 48;      // CQ requests in the whole run, rounded up
   localparam int          MAX_LEN  = 8;       // Beats per TLP
   localparam int          MAX_TLPS = 6;
   localparam int          N_DMA    = 2;
   localparam int          WATCHDOG_CYCLES =
      N_REQ * 24 + N_DMA * MAX_TLPS * (MAX_LEN + 1) * 8 + 400;

   logic              user_clk;
   logic              arst_n;
   bmd_axis_beat_t    cq_beat;
   logic              cq_tvalid;
   logic              cq_tready;
   bmd_axis_beat_t    cc_beat;
   logic              cc_tvalid;
   logic              cc_tready;
   bmd_axis_beat_t    rq_beat;
   logic              rq_tvalid;
   logic              rq_tready;
   logic              sent;
   logic              intx;
   logic              irq_done;

   logic [31:0]       shadow [8];     // Register map as the host sees it
   logic [31:0]       stim_rng;
   bmd_axis_beat_t    cc_exp [$];
   bmd_axis_beat_t    rq_exp [$];
   logic              intx_q       = 1'b0;
   int                intx_rises   = 0;
   int                intx_falls   = 0;
   int                irq_done_cnt = 0;
   int                sent_cnt     = 0;

   initial begin
      user_clk = 1'b0;
      forever #4 user_clk = ~user_clk;
   end

   bmd_ep_top u_bmd_ep_top (
      .user_clk_i           ( user_clk ),
      .arst_n_i             ( arst_n ),
      .cq_beat_i            ( cq_beat ),
      .cq_tvalid_i          ( cq_tvalid ),
      .cq_tready_o          ( cq_tready ),
      .cc_beat_o            ( cc_beat ),
      .cc_tvalid_o          ( cc_tvalid ),
      .cc_tready_i          ( cc_tready ),
      .rq_beat_o            ( rq_beat ),
      .rq_tvalid_o          ( rq_tvalid ),
      .rq_tready_i          ( rq_tready ),
      .cfg_interrupt_sent_i ( sent ),
      .intx_o               ( intx ),
      .interrupt_done_o     ( irq_done )
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      stim_rng = xorshift32(stim_rng);
      return stim_rng;
   endfunction

   task automatic report_fail();
      $display("Test FAILED");
      $fatal(1);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Beat 0 is the descriptor, beat 1 the read data
   function automatic bmd_axis_beat_t ref_cc_beat(input bmd_cq_desc_t rq, input int beat);
      bmd_cc_desc_t   d;
      bmd_axis_beat_t b;
      logic           is_rd;
      is_rd        = (rq.req_type == `BMD_REQ_MRD);
      d            = '0;
      d.status     = is_rd ? `BMD_CPL_SC : `BMD_CPL_UR;
      d.byte_count = is_rd ? 13'd4 : 13'd0;
      d.req_id     = rq.req_id;
      d.tag        = rq.tag;
      d.tc         = rq.tc;
      d.lower_addr = {rq.dw_addr[4:0], 2'b00};     // Byte address bits 6:0
      if (beat == 0) begin
         b.data = d;
         b.last = ~is_rd;
      end else begin
         b.data = {32'h0, shadow[rq.dw_addr[2:0]]};
         b.last = 1'b1;
      end
      return b;
   endfunction

   function automatic bmd_axis_beat_t ref_rq_beat(input logic [31:0] addr,
         input logic [15:0] len, input logic [31:0] pattern, input int tlp, input int beat);
      bmd_rq_desc_t   d;
      bmd_axis_beat_t b;
      d           = '0;
      d.req_type  = `BMD_REQ_MWR;
      d.byte_addr = addr + 32'(tlp) * 32'(len) * 32'd8;   // Eight bytes per beat
      d.dw_count  = 11'(2 * int'(len));
      d.tag       = 8'(tlp);
      if (beat == 0) begin
         b.data = d;
         b.last = 1'b0;
      end else begin
         b.data = {pattern, pattern};
         b.last = (beat == int'(len));
      end
      return b;
   endfunction

   task automatic queue_dma();
      logic [15:0] len;
      logic [15:0] cnt;
      int          t;
      int          k;
      len = shadow[`BMD_REG_WR_LEN][15:0];
      cnt = shadow[`BMD_REG_WR_COUNT][15:0];
      for (t = 0; t < int'(cnt); t++)
         for (k = 0; k <= int'(len); k++)
            rq_exp.push_back(ref_rq_beat(shadow[`BMD_REG_WR_ADDR], len,
                                         shadow[`BMD_REG_WR_DATA], t, k));
   endtask

   task automatic shadow_write(input logic [2:0] idx, input logic [31:0] data);
      case (idx)
         `BMD_REG_CTRL: begin
            shadow[`BMD_REG_CTRL] = {data[31:2], 2'b00};
            if (data[0]) begin                          // Soft init
               shadow[`BMD_REG_STATUS]   = '0;
               shadow[`BMD_REG_WR_ADDR]  = '0;
               shadow[`BMD_REG_WR_LEN]   = '0;
               shadow[`BMD_REG_WR_COUNT] = '0;
               shadow[`BMD_REG_WR_DATA]  = '0;
            end else if (data[1]) begin
               shadow[`BMD_REG_STATUS][0] = 1'b0;
               queue_dma();
            end
         end
         `BMD_REG_STATUS, `BMD_REG_ID: ;               // Read-only
         default: shadow[idx] = data;
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus, called on a falling edge
   //////////////////////////////////////////////////////////////////////
   task automatic send_cq_beat(input logic [63:0] data, input logic last);
      cq_beat.data = data;
      cq_beat.last = last;
      cq_tvalid    = 1'b1;
      while (!cq_tready)
         @(negedge user_clk);
      @(negedge user_clk);                              // Taken at the edge between
      cq_tvalid = 1'b0;
   endtask

   task automatic cq_request(input logic [3:0] req_type, input logic [2:0] idx,
         input logic [31:0] data, input logic with_payload);
      bmd_cq_beat_u u;
      logic [31:0]  r;
      r               = next_rand();
      u.raw           = '0;
      u.desc.req_type = req_type;
      u.desc.dw_addr  = {r[7:0], idx};                // Upper bits ignored by the map
      u.desc.dw_count = 11'd1;
      u.desc.req_id   = r[31:16];
      u.desc.tag      = r[15:8];
      u.desc.tc       = r[10:8];
      if (req_type == `BMD_REQ_MWR) begin
         shadow_write(idx, data);
      end else begin
         cc_exp.push_back(ref_cc_beat(u.desc, 0));
         if (req_type == `BMD_REQ_MRD)
            cc_exp.push_back(ref_cc_beat(u.desc, 1));
      end
      send_cq_beat(u.raw, ~with_payload);
      if (with_payload)
         send_cq_beat({r, data}, 1'b1);
      while (cc_exp.size() != 0)
         @(negedge user_clk);
   endtask

   task automatic write_reg(input logic [2:0] idx, input logic [31:0] data);
      cq_request(`BMD_REQ_MWR, idx, data, 1'b1);
   endtask

   task automatic read_reg(input logic [2:0] idx);
      cq_request(`BMD_REQ_MRD, idx, 32'h0, 1'b0);
   endtask

   // Random ready on both outgoing streams, three cycles in four
   initial begin : backpressure
      logic [31:0] r;
      r = SEED;
      forever begin
         @(negedge user_clk);
         r         = xorshift32(r);
         cc_tready = (r[1:0] != 2'b00);
         rq_tready = (r[5:4] != 2'b00);
      end
   end

   // Core side of the INTx exchange
   initial begin : intx_core_model
      logic seen;
      seen = 1'b0;
      forever begin
         @(negedge user_clk);
         if (intx !== seen) begin
            seen = intx;
            repeat (3) @(negedge user_clk);
            sent = 1'b1;
            @(negedge user_clk);
            sent = 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Compare process
   //////////////////////////////////////////////////////////////////////
   always @(posedge user_clk) begin : beat_checker
      bmd_axis_beat_t exp;
      if (cc_tvalid && cc_tready) begin
         assert (cc_exp.size() > 0) else begin
            $display("Unexpected CC beat at %0t with no request outstanding", $time);
            report_fail();
         end
         exp = cc_exp.pop_front();
         assert (cc_beat === exp) else begin
            $display("MISMATCH at %0t: CC beat %h last %b, expected %h last %b",
                     $time, cc_beat.data, cc_beat.last, exp.data, exp.last);
            report_fail();
         end
      end
      if (rq_tvalid && rq_tready) begin
         assert (rq_exp.size() > 0) else begin
            $display("Unexpected RQ beat at %0t beyond the programmed count", $time);
            report_fail();
         end
         exp = rq_exp.pop_front();
         assert (rq_beat === exp) else begin
            $display("MISMATCH at %0t: RQ beat %h last %b, expected %h last %b",
                     $time, rq_beat.data, rq_beat.last, exp.data, exp.last);
            report_fail();
         end
      end
      intx_q <= intx;
      if (intx && !intx_q)
         intx_rises++;
      if (!intx && intx_q)
         intx_falls++;
      if (irq_done)
         irq_done_cnt++;
      if (sent)
         sent_cnt++;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge user_clk);
      $display("Watchdog expired after %0d cycles, the DUT stopped responding",
               WATCHDOG_CYCLES);
      report_fail();
   end

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////
   initial begin : main_seq
      logic [31:0] v;
      logic [31:0] cnt;
      int          i;
      arst_n    = 1'b0;
      cq_beat   = '0;
      cq_tvalid = 1'b0;
      cc_tready = 1'b0;
      rq_tready = 1'b0;
      sent      = 1'b0;
      stim_rng  = SEED;
      for (i = 0; i < 8; i++)
         shadow[i] = '0;
      shadow[`BMD_REG_ID] = `BMD_ID_VALUE;
      repeat (2) @(negedge user_clk);
      assert (!cq_tready && !cc_tvalid && !rq_tvalid && !intx && !irq_done) else begin
         $display("MISMATCH at %0t: control output active during reset", $time);
         report_fail();
      end
      arst_n = 1'b1;
      @(negedge user_clk);

      // Scratch and DMA registers
      for (i = 0; i < 4; i++) begin
         write_reg(`BMD_REG_SCRATCH, next_rand());
         read_reg(`BMD_REG_SCRATCH);
      end
      for (i = 2; i <= 5; i++) begin
         write_reg(3'(i), next_rand());
         read_reg(3'(i));
      end

      // ID and STATUS ignore writes
      read_reg(`BMD_REG_ID);
      write_reg(`BMD_REG_ID, next_rand());
      read_reg(`BMD_REG_ID);
      write_reg(`BMD_REG_STATUS, 32'hFFFF_FFFF);
      read_reg(`BMD_REG_STATUS);

      // Unsupported types, one with a payload aimed at scratch
      v = next_rand();
      write_reg(`BMD_REG_SCRATCH, v);
      cq_request(4'd5, `BMD_REG_SCRATCH, ~v, 1'b1);
      cq_request(4'd2, `BMD_REG_SCRATCH, 32'h0, 1'b0);
      read_reg(`BMD_REG_SCRATCH);

      // DMA with the interrupt enabled
      write_reg(`BMD_REG_CTRL, 32'h1);
      write_reg(`BMD_REG_WR_ADDR, next_rand() & 32'hFFFF_FFF8);
      v = next_rand();
      cnt = 32'(v[5:3] % 3'd6) + 32'd1;
      write_reg(`BMD_REG_WR_LEN, 32'(v[2:0]) + 32'd1);
      write_reg(`BMD_REG_WR_COUNT, cnt);
      write_reg(`BMD_REG_WR_DATA, next_rand());
      write_reg(`BMD_REG_CTRL, 32'h2);
      while (rq_exp.size() != 0)
         @(negedge user_clk);
      assert (!rq_tvalid) else begin
         $display("MISMATCH at %0t: RQ still valid after the last of %0d TLPs", $time, cnt);
         report_fail();
      end
      shadow[`BMD_REG_STATUS][0] = 1'b1;
      while (irq_done_cnt < 1)
         @(negedge user_clk);
      repeat (8) @(negedge user_clk);
      assert (intx_rises == 1 && intx_falls == 1 && irq_done_cnt == 1 && sent_cnt == 2 && !intx)
         else begin
         $display("MISMATCH at %0t: INTx rises %0d falls %0d done %0d sent %0d",
                  $time, intx_rises, intx_falls, irq_done_cnt, sent_cnt);
         report_fail();
      end
      read_reg(`BMD_REG_STATUS);

      // Second DMA with the interrupt disabled
      v = next_rand();
      write_reg(`BMD_REG_WR_LEN, 32'(v[2:0]) + 32'd1);
      write_reg(`BMD_REG_WR_COUNT, 32'(v[5:3] % 3'd6) + 32'd1);
      write_reg(`BMD_REG_WR_DATA, next_rand());
      write_reg(`BMD_REG_CTRL, 32'h6);
      while (rq_exp.size() != 0)
         @(negedge user_clk);
      shadow[`BMD_REG_STATUS][0] = 1'b1;
      repeat (20) @(negedge user_clk);
      assert (intx_rises == 1 && irq_done_cnt == 1 && !intx) else begin
         $display("MISMATCH at %0t: INTx raised with the interrupt disabled", $time);
         report_fail();
      end
      read_reg(`BMD_REG_STATUS);
      read_reg(`BMD_REG_CTRL);

      repeat (4) @(negedge user_clk);
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: bmd_ep_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module bmd_ep_top (
   input  wire logic                     user_clk_i,
   input  wire logic                     arst_n_i,
   // Completer request
   input  wire bmd_pkg::bmd_axis_beat_t  cq_beat_i,
   input  wire logic                     cq_tvalid_i,
   output logic                          cq_tready_o,
   // Completer completion
   output bmd_pkg::bmd_axis_beat_t       cc_beat_o,
   output logic                          cc_tvalid_o,
   input  wire logic                     cc_tready_i,
   // Requester request
   output bmd_pkg::bmd_axis_beat_t       rq_beat_o,
   output logic                          rq_tvalid_o,
   input  wire logic                     rq_tready_i,
   // Legacy interrupt
   input  wire logic                     cfg_interrupt_sent_i,
   output logic                          intx_o,
   output logic                          interrupt_done_o
);
   import bmd_pkg::*;

   bmd_compl_req_t                 compl;
   bmd_dma_cfg_t                   dma_cfg;
   logic                           compl_req;
   logic                           compl_done;
   logic                           wr_en;
   logic [`BMD_REG_IDX_W-1:0]      wr_idx;
   logic [31:0]                    wr_data;
   logic [`BMD_REG_IDX_W-1:0]      rd_idx;
   logic [31:0]                    rd_data;
   logic                           dma_start;
   logic                           dma_done;
   logic                           int_dis;

   bmd_cq_rx u_cq_rx (
      .user_clk_i    ( user_clk_i ),
      .arst_n_i      ( arst_n_i ),
      .cq_beat_i     ( cq_beat_i ),
      .cq_tvalid_i   ( cq_tvalid_i ),
      .cq_tready_o   ( cq_tready_o ),
      .compl_req_o   ( compl_req ),
      .compl_o       ( compl ),
      .compl_done_i  ( compl_done ),
      .wr_en_o       ( wr_en ),
      .reg_idx_o     ( wr_idx ),
      .wr_data_o     ( wr_data )
   );

   bmd_mem_access u_mem_access (
      .user_clk_i    ( user_clk_i ),
      .arst_n_i      ( arst_n_i ),
      .wr_en_i       ( wr_en ),
      .wr_idx_i      ( wr_idx ),
      .wr_data_i     ( wr_data ),
      .rd_idx_i      ( rd_idx ),
      .rd_data_o     ( rd_data ),
      .dma_start_o   ( dma_start ),
      .dma_cfg_o     ( dma_cfg ),
      .dma_done_i    ( dma_done ),
      .int_dis_o     ( int_dis )
   );

   bmd_cc_tx u_cc_tx (
      .user_clk_i    ( user_clk_i ),
      .arst_n_i      ( arst_n_i ),
      .compl_req_i   ( compl_req ),
      .compl_i       ( compl ),
      .compl_done_o  ( compl_done ),
      .rd_idx_o      ( rd_idx ),
      .rd_data_i     ( rd_data ),
      .cc_beat_o     ( cc_beat_o ),
      .cc_tvalid_o   ( cc_tvalid_o ),
      .cc_tready_i   ( cc_tready_i )
   );

   bmd_rq_tx u_rq_tx (
      .user_clk_i    ( user_clk_i ),
      .arst_n_i      ( arst_n_i ),
      .dma_start_i   ( dma_start ),
      .dma_cfg_i     ( dma_cfg ),
      .dma_done_o    ( dma_done ),
      .rq_beat_o     ( rq_beat_o ),
      .rq_tvalid_o   ( rq_tvalid_o ),
      .rq_tready_i   ( rq_tready_i )
   );

   bmd_intr_ctrl u_intr_ctrl (
      .user_clk_i           ( user_clk_i ),
      .arst_n_i             ( arst_n_i ),
      .dma_done_i           ( dma_done ),
      .int_dis_i            ( int_dis ),
      .cfg_interrupt_sent_i ( cfg_interrupt_sent_i ),
      .intx_o               ( intx_o ),
      .interrupt_done_o     ( interrupt_done_o )
   );

endmodule

`default_nettype wire

// File: bmd_intr_ctrl.sv
`default_nettype none
`timescale 1ns/10ps

module bmd_intr_ctrl (
   input  wire logic   user_clk_i,
   input  wire logic   arst_n_i,
   input  wire logic   dma_done_i,
   input  wire logic   int_dis_i,
   input  wire logic   cfg_interrupt_sent_i,
   output logic        intx_o,
   output logic        interrupt_done_o
);

   typedef enum logic [1:0] {S_IDLE, S_ASSERT, S_DEASSERT, S_DONE} state_t;

   state_t   state;

   assign intx_o           = (state == S_ASSERT);   // INTA level
   assign interrupt_done_o = (state == S_DONE);

   // Assert, wait for sent, deassert, wait for sent again
   always_ff @(posedge user_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE:     if (dma_done_i && !int_dis_i) state <= S_ASSERT;
            S_ASSERT:   if (cfg_interrupt_sent_i) state <= S_DEASSERT;
            S_DEASSERT: if (cfg_interrupt_sent_i) state <= S_DONE;
            default:    state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: bmd_rq_tx.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module bmd_rq_tx (
   input  wire logic                     user_clk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     dma_start_i,
   input  wire bmd_pkg::bmd_dma_cfg_t    dma_cfg_i,
   output logic                          dma_done_o,
   output bmd_pkg::bmd_axis_beat_t       rq_beat_o,
   output logic                          rq_tvalid_o,
   input  wire logic                     rq_tready_i
);
   import bmd_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_DESC, S_DATA} state_t;

   state_t         state;
   bmd_dma_cfg_t   cfg_q;        // Settings frozen for the whole transfer
   bmd_rq_desc_t   rq_desc;
   logic [31:0]    cur_addr;
   logic [15:0]    tlp_cnt;
   logic [15:0]    beat_cnt;
   logic           take;
   logic           last_beat;
   logic           last_tlp;

   assign rq_tvalid_o = (state != S_IDLE);
   assign take        = rq_tvalid_o & rq_tready_i;
   assign last_beat   = (beat_cnt == cfg_q.wr_len - 16'd1);
   assign last_tlp    = (tlp_cnt == cfg_q.tlp_count - 16'd1);
   assign dma_done_o  = take & (state == S_DATA) & last_beat & last_tlp;

   always_comb begin
      rq_desc           = '0;
      rq_desc.req_type  = `BMD_REQ_MWR;
      rq_desc.byte_addr = cur_addr;
      rq_desc.dw_count  = {cfg_q.wr_len[9:0], 1'b0};   // Two dwords per beat
      rq_desc.tag       = tlp_cnt[7:0];
      rq_beat_o.data    = (state == S_DATA) ? {2{cfg_q.pattern}} : rq_desc;
      rq_beat_o.last    = (state == S_DATA) & last_beat;
   end

   ////////////////////////////////////////////////////////////////////////
   // TLP and beat sequencing
   ////////////////////////////////////////////////////////////////////////
   always_ff @(posedge user_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state    <= S_IDLE;
         tlp_cnt  <= '0;
         beat_cnt <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               if (dma_start_i) begin         // Start while busy never lands here
                  state   <= S_DESC;
                  tlp_cnt <= '0;
               end
            end
            S_DESC: begin
               if (take) begin
                  state    <= S_DATA;
                  beat_cnt <= '0;
               end
            end
            S_DATA: begin
               if (take) begin
                  beat_cnt <= beat_cnt + 16'd1;
                  if (last_beat) begin
                     tlp_cnt <= tlp_cnt + 16'd1;
                     state   <= last_tlp ? S_IDLE : S_DESC;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge user_clk_i) begin
      if (state == S_IDLE && dma_start_i) begin
         cfg_q    <= dma_cfg_i;
         cur_addr <= dma_cfg_i.wr_addr;
      end else if (state == S_DATA && take && last_beat) begin
         cur_addr <= cur_addr + {13'd0, cfg_q.wr_len, 3'b000};   // Next TLP base
      end
   end

endmodule

`default_nettype wire

// File: bmd_cc_tx.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module bmd_cc_tx (
   input  wire logic                     user_clk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     compl_req_i,
   input  wire bmd_pkg::bmd_compl_req_t  compl_i,
   output logic                          compl_done_o,
   output logic [`BMD_REG_IDX_W-1:0]     rd_idx_o,
   input  wire logic [31:0]              rd_data_i,
   output bmd_pkg::bmd_axis_beat_t       cc_beat_o,
   output logic                          cc_tvalid_o,
   input  wire logic                     cc_tready_i
);
   import bmd_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_DESC, S_DATA} state_t;

   state_t         state;
   bmd_cc_desc_t   cc_desc;
   logic           take;

   assign rd_idx_o     = compl_i.dw_addr[`BMD_REG_IDX_W-1:0];
   assign cc_tvalid_o  = (state != S_IDLE);
   assign take         = cc_tvalid_o & cc_tready_i;
   assign compl_done_o = take & cc_beat_o.last;

   always_comb begin
      cc_desc            = '0;
      cc_desc.status     = compl_i.status;
      cc_desc.byte_count = compl_i.with_data ? 13'd4 : 13'd0;   // Nothing returned on UR
      cc_desc.req_id     = compl_i.req_id;
      cc_desc.tag        = compl_i.tag;
      cc_desc.tc         = compl_i.tc;
      cc_desc.lower_addr = {compl_i.dw_addr[4:0], 2'b00};
   end

   always_ff @(posedge user_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: if (compl_req_i) state <= S_DESC;
            S_DESC: if (take) state <= compl_i.with_data ? S_DATA : S_IDLE;
            S_DATA: if (take) state <= S_IDLE;
            default: state <= S_IDLE;
         endcase
      end
   end

   // Beat register, loaded only when the previous beat is gone
   always_ff @(posedge user_clk_i) begin
      if (state == S_IDLE && compl_req_i) begin
         cc_beat_o.data <= cc_desc;
         cc_beat_o.last <= ~compl_i.with_data;
      end else if (state == S_DESC && take) begin
         cc_beat_o.data <= {32'h0, rd_data_i};   // Register value in low dword
         cc_beat_o.last <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: bmd_mem_access.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module bmd_mem_access (
   input  wire logic                     user_clk_i,
   input  wire logic                     arst_n_i,
   input  wire logic                     wr_en_i,
   input  wire logic [`BMD_REG_IDX_W-1:0] wr_idx_i,
   input  wire logic [31:0]              wr_data_i,
   input  wire logic [`BMD_REG_IDX_W-1:0] rd_idx_i,
   output logic [31:0]                   rd_data_o,
   output logic                          dma_start_o,
   output bmd_pkg::bmd_dma_cfg_t         dma_cfg_o,
   input  wire logic                     dma_done_i,
   output logic                          int_dis_o
);
   import bmd_pkg::*;

   bmd_regfile_t   regs;

   assign rd_data_o = regs[rd_idx_i];

   assign dma_cfg_o.wr_addr   = regs[`BMD_REG_WR_ADDR];
   assign dma_cfg_o.wr_len    = regs[`BMD_REG_WR_LEN][15:0];
   assign dma_cfg_o.tlp_count = regs[`BMD_REG_WR_COUNT][15:0];
   assign dma_cfg_o.pattern   = regs[`BMD_REG_WR_DATA];
   assign int_dis_o           = regs[`BMD_REG_CTRL][2];

   ////////////////////////////////////////////////////////////////////////
   // Register map writes
   ////////////////////////////////////////////////////////////////////////
   always_ff @(posedge user_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         regs                <= '0;
         regs[`BMD_REG_ID]   <= `BMD_ID_VALUE;
         dma_start_o         <= 1'b0;
      end else begin
         dma_start_o <= 1'b0;
         if (dma_done_i)
            regs[`BMD_REG_STATUS][0] <= 1'b1;
         if (wr_en_i) begin
            case (wr_idx_i)
               `BMD_REG_CTRL: begin
                  regs[`BMD_REG_CTRL] <= {wr_data_i[31:2], 2'b00};  // Bits 1:0 self-clear
                  if (wr_data_i[0]) begin                           // Soft init of DMA regs
                     regs[`BMD_REG_STATUS]   <= '0;
                     regs[`BMD_REG_WR_ADDR]  <= '0;
                     regs[`BMD_REG_WR_LEN]   <= '0;
                     regs[`BMD_REG_WR_COUNT] <= '0;
                     regs[`BMD_REG_WR_DATA]  <= '0;
                  end else if (wr_data_i[1]) begin
                     dma_start_o              <= 1'b1;
                     regs[`BMD_REG_STATUS][0] <= 1'b0;
                  end
               end
               `BMD_REG_STATUS, `BMD_REG_ID: ;   // Read-only
               default: regs[wr_idx_i] <= wr_data_i;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: bmd_cq_rx.sv
`default_nettype none
`timescale 1ns/10ps
`include "bmd_params.svh"

module bmd_cq_rx (
   input  wire logic                     user_clk_i,
   input  wire logic                     arst_n_i,
   input  wire bmd_pkg::bmd_axis_beat_t  cq_beat_i,
   input  wire logic                     cq_tvalid_i,
   output logic                          cq_tready_o,
   output logic                          compl_req_o,
   output bmd_pkg::bmd_compl_req_t       compl_o,
   input  wire logic                     compl_done_i,
   output logic                          wr_en_o,
   output logic [`BMD_REG_IDX_W-1:0]     reg_idx_o,
   output logic [31:0]                   wr_data_o
);
   import bmd_pkg::*;

   typedef enum logic {S_DESC, S_DATA} state_t;

   state_t         state;
   bmd_cq_beat_u   cq_u;
   bmd_cq_desc_t   desc;
   logic           rx_en;      // Opens tready once out of reset
   logic           is_wr;
   logic           beat_ok;
   logic           is_mrd;

   assign cq_u    = cq_beat_i.data;
   assign desc    = cq_u.desc;
   assign is_mrd  = (desc.req_type == `BMD_REQ_MRD);

   // No new request while a completion is outstanding
   assign cq_tready_o = rx_en & ~compl_req_o;
   assign beat_ok     = cq_tvalid_i & cq_tready_o;

   always_ff @(posedge user_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state       <= S_DESC;
         rx_en       <= 1'b0;
         is_wr       <= 1'b0;
         compl_req_o <= 1'b0;
         wr_en_o     <= 1'b0;
      end else begin
         rx_en   <= 1'b1;
         wr_en_o <= 1'b0;
         if (compl_done_i)
            compl_req_o <= 1'b0;
         if (beat_ok) begin
            case (state)
               S_DESC: begin
                  is_wr <= (desc.req_type == `BMD_REQ_MWR);
                  if (desc.req_type != `BMD_REQ_MWR)
                     compl_req_o <= 1'b1;          // Reads and UR, writes are posted
                  if (!cq_beat_i.last)
                     state <= S_DATA;
               end
               S_DATA: begin
                  wr_en_o <= is_wr;                  // First payload dword only
                  is_wr   <= 1'b0;
                  if (cq_beat_i.last)
                     state <= S_DESC;
               end
               default: state <= S_DESC;
            endcase
         end
      end
   end

   // Latched request fields
   always_ff @(posedge user_clk_i) begin
      if (beat_ok && state == S_DESC) begin
         compl_o.with_data <= is_mrd;
         compl_o.status    <= is_mrd ? `BMD_CPL_SC : `BMD_CPL_UR;
         compl_o.req_id    <= desc.req_id;
         compl_o.tag       <= desc.tag;
         compl_o.tc        <= desc.tc;
         compl_o.dw_addr   <= desc.dw_addr;
         reg_idx_o         <= desc.dw_addr[`BMD_REG_IDX_W-1:0];
      end
      if (beat_ok && state == S_DATA)
         wr_data_o <= cq_u.raw[31:0];
   end

endmodule

`default_nettype wire

// File: bmd_pkg.sv
`default_nettype none
`include "bmd_params.svh"

package bmd_pkg;

   // CQ request descriptor, first beat of a request
   typedef struct packed {
      logic [10:0]             rsvd;
      logic [2:0]              tc;
      logic [7:0]              tag;
      logic [15:0]             req_id;
      logic [10:0]             dw_count;
      logic [`BMD_ADDR_W-1:0]  dw_addr;
      logic [3:0]              req_type;
   } bmd_cq_desc_t;

   // Same CQ word seen as descriptor or as payload
   typedef union packed {
      bmd_cq_desc_t            desc;
      logic [`BMD_DATA_W-1:0]  raw;
   } bmd_cq_beat_u;

   typedef struct packed {
      logic [`BMD_DATA_W-1:0]  data;
      logic                    last;
   } bmd_axis_beat_t;

   // Completion request, CQ receiver to CC transmitter
   typedef struct packed {
      logic                    with_data;
      logic [2:0]              status;
      logic [15:0]             req_id;
      logic [7:0]              tag;
      logic [2:0]              tc;
      logic [`BMD_ADDR_W-1:0]  dw_addr;
   } bmd_compl_req_t;

   typedef struct packed {
      logic [13:0]             rsvd;
      logic [2:0]              status;
      logic [12:0]             byte_count;
      logic [15:0]             req_id;
      logic [7:0]              tag;
      logic [2:0]              tc;
      logic [6:0]              lower_addr;
   } bmd_cc_desc_t;

   typedef struct packed {
      logic [8:0]              rsvd;
      logic [7:0]              tag;
      logic [10:0]             dw_count;
      logic [31:0]             byte_addr;
      logic [3:0]              req_type;
   } bmd_rq_desc_t;

   // DMA write settings from the register file
   typedef struct packed {
      logic [31:0]             wr_addr;
      logic [15:0]             wr_len;     // Beats per TLP
      logic [15:0]             tlp_count;
      logic [31:0]             pattern;
   } bmd_dma_cfg_t;

   // Whole register map
   typedef logic [(1 << `BMD_REG_IDX_W)-1:0][31:0] bmd_regfile_t;

endpackage

`default_nettype wire

// File: bmd_params.svh
`ifndef BMD_PARAMS_SVH
`define BMD_PARAMS_SVH

// Stream and request geometry
`define BMD_DATA_W          64
`define BMD_ADDR_W          11     // Dword address of a request
`define BMD_REG_IDX_W       3      // Eight registers

// Register map, dword index
`define BMD_REG_CTRL        3'd0
`define BMD_REG_STATUS      3'd1
`define BMD_REG_WR_ADDR     3'd2
`define BMD_REG_WR_LEN      3'd3
`define BMD_REG_WR_COUNT    3'd4
`define BMD_REG_WR_DATA     3'd5
`define BMD_REG_SCRATCH     3'd6
`define BMD_REG_ID          3'd7

`define BMD_ID_VALUE        32'hB3D0_0A01

// Request types and completion status
`define BMD_REQ_MRD         4'd0
`define BMD_REQ_MWR         4'd1
`define BMD_CPL_SC          3'd0
`define BMD_CPL_UR          3'd1

`endif
